/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_fetch_unit
FILELIST  := filelist.f
OBJDIR    := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module branch_predictor
    import fetch_pkg::*;
#(
    parameter int ENTRIES = `BP_ENTRIES
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] pc,
    output logic [31:0] next_pc,
    input  bp_update_t  update
);

    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    logic [ENTRIES-1:0] valid;
    logic [TAG_W-1:0]   tag    [ENTRIES];
    logic [31:0]        target [ENTRIES];
    logic [1:0]         ctr    [ENTRIES];

    logic [IDX_W-1:0]   rd_idx;
    logic               rd_taken;
    logic [IDX_W-1:0]   upd_idx;
    logic               upd_hit;

    // index skips the byte offset, tag is everything above it
    assign rd_idx   = pc[IDX_W+1:2];
    assign rd_taken = valid[rd_idx] && (tag[rd_idx] == pc[31:IDX_W+2])
                      && ctr[rd_idx][1];
    assign next_pc  = rd_taken ? target[rd_idx] : pc + 32'd4;

    assign upd_idx = update.pc[IDX_W+1:2];
    assign upd_hit = valid[upd_idx] && (tag[upd_idx] == update.pc[31:IDX_W+2]);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (update.valid && (upd_hit || update.taken)) begin
            valid[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid) begin
            if (!upd_hit) begin
                // allocate on taken only, start weakly taken
                if (update.taken) begin
                    tag[upd_idx]    <= update.pc[31:IDX_W+2];
                    target[upd_idx] <= update.target;
                    ctr[upd_idx]    <= 2'd2;
                end
            end else if (update.taken) begin
                target[upd_idx] <= update.target;
                if (ctr[upd_idx] != 2'd3) begin
                    ctr[upd_idx] <= ctr[upd_idx] + 2'd1;
                end
            end else if (ctr[upd_idx] != 2'd0) begin
                ctr[upd_idx] <= ctr[upd_idx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic                                    clk,
    input  logic                                    reset,
    output mem_req_t                                mem_req,
    input  logic                                    mem_ready,
    input  mem_resp_t                               mem_resp,
    input  redirect_t                               redirect,
    input  logic [$clog2(`FETCH_QUEUE_DEPTH+1)-1:0] queue_free,
    output logic                                    queue_push,
    output logic                                    queue_flush,
    output logic [31:0]                             lookup_pc,
    input  logic [31:0]                             predicted_next,
    input  logic                                    jal_hit,
    input  logic [31:0]                             jal_target
);

    logic [31:0] pc;
    logic        requested;
    logic        drop_pending;
    logic        running;

    logic        resp_arrive;
    logic        resp_good;
    logic        take_jal;
    logic [31:0] req_addr;
    logic        req_fire;
    logic        outstanding_next;

    // memory answers only while a read is outstanding
    assign resp_arrive = requested && mem_resp.valid;
    assign resp_good   = resp_arrive && !drop_pending;

    // a returned JAL steers the request going out in the same cycle
    assign take_jal = resp_good && jal_hit;
    assign req_addr = take_jal ? jal_target : pc;

    // two free slots: one for the response now, one for the new read
    assign mem_req.valid = running && (!requested || resp_arrive) && (queue_free >= 2);
    assign mem_req.addr  = req_addr;
    assign req_fire      = mem_req.valid && mem_ready;

    assign lookup_pc = req_addr;

    assign outstanding_next = req_fire || (requested && !resp_arrive);

    assign queue_push  = resp_good && !redirect.valid;
    assign queue_flush = redirect.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc           <= `FETCH_RESET_PC;
            requested    <= 1'b0;
            drop_pending <= 1'b0;
            running      <= 1'b0;
        end else begin
            running   <= 1'b1;
            requested <= outstanding_next;
            if (redirect.valid) begin
                pc           <= redirect.addr;
                // whatever is still in flight belongs to the old path
                drop_pending <= outstanding_next;
            end else begin
                if (resp_arrive) begin
                    drop_pending <= 1'b0;
                end
                if (req_fire) begin
                    pc <= predicted_next;
                end else if (take_jal) begin
                    // hold the jump target until memory takes it
                    pc <= jal_target;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h0000_0000

// fetch queue entries
`define FETCH_QUEUE_DEPTH 8

// predictor table size, power of two
`define BP_ENTRIES 16

`define JAL_OPCODE 7'b1101111

`endif

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // one queued instruction with its address
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] inst;
    } fetch_entry_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [31:0] inst;
    } mem_resp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } redirect_t;

    // resolved branch from execute
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
    } bp_update_t;

endpackage

`default_nettype wire

/* fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_queue
    import fetch_pkg::*;
#(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic                         push,
    input  fetch_entry_t                 push_data,
    output logic [$clog2(DEPTH+1)-1:0]   free,
    output logic                         pop_valid,
    input  logic                         pop_ready,
    output fetch_entry_t                 pop_data
);

    localparam int PTR_W  = $clog2(DEPTH);
    localparam int FREE_W = $clog2(DEPTH + 1);

    fetch_entry_t       mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               do_push;
    logic               do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        next_ptr = (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // empty when every slot is free
    assign pop_valid = (free != FREE_W'(DEPTH));
    assign pop_data  = mem[rd_ptr];
    assign do_push   = push && (free != '0);
    assign do_pop    = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            free   <= FREE_W'(DEPTH);
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   free <= free - 1'b1;
                2'b01:   free <= free + 1'b1;
                default: free <= free;
            endcase
        end
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    output mem_req_t     mem_req,
    input  logic         mem_ready,
    input  mem_resp_t    mem_resp,
    input  redirect_t    redirect,
    input  bp_update_t   bp_update,
    output fetch_entry_t fetch_out,
    output logic         fetch_valid,
    input  logic         fetch_ready
);

    localparam int FREE_W = $clog2(`FETCH_QUEUE_DEPTH + 1);

    logic [FREE_W-1:0] queue_free;
    logic              queue_push;
    logic              queue_flush;
    fetch_entry_t      push_entry;
    logic [31:0]       lookup_pc;
    logic [31:0]       predicted_next;
    logic              jal_hit;
    logic [31:0]       jal_target;

    assign push_entry = '{addr: mem_resp.addr, inst: mem_resp.inst};

    fetch_ctrl i_fetch_ctrl (
        .clk            (clk),
        .reset          (reset),
        .mem_req        (mem_req),
        .mem_ready      (mem_ready),
        .mem_resp       (mem_resp),
        .redirect       (redirect),
        .queue_free     (queue_free),
        .queue_push     (queue_push),
        .queue_flush    (queue_flush),
        .lookup_pc      (lookup_pc),
        .predicted_next (predicted_next),
        .jal_hit        (jal_hit),
        .jal_target     (jal_target)
    );

    fetch_queue #(
        .DEPTH (`FETCH_QUEUE_DEPTH)
    ) i_fetch_queue (
        .clk       (clk),
        .reset     (reset),
        .flush     (queue_flush),
        .push      (queue_push),
        .push_data (push_entry),
        .free      (queue_free),
        .pop_valid (fetch_valid),
        .pop_ready (fetch_ready),
        .pop_data  (fetch_out)
    );

    branch_predictor #(
        .ENTRIES (`BP_ENTRIES)
    ) i_branch_predictor (
        .clk     (clk),
        .reset   (reset),
        .pc      (lookup_pc),
        .next_pc (predicted_next),
        .update  (bp_update)
    );

    // predecode looks at the word coming back from memory
    jal_predecode i_jal_predecode (
        .addr   (mem_resp.addr),
        .inst   (mem_resp.inst),
        .hit    (jal_hit),
        .target (jal_target)
    );

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
fetch_pkg.sv
fetch_queue.sv
branch_predictor.sv
jal_predecode.sv
fetch_ctrl.sv
fetch_unit.sv
tb_imem.sv
tb_fetch_unit.sv

/* jal_predecode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module jal_predecode (
    input  logic [31:0] addr,
    input  logic [31:0] inst,
    output logic        hit,
    output logic [31:0] target
);

    logic [6:0]  opcode;
    logic [31:0] imm_j;

    assign opcode = inst[6:0];

    // J-type immediate, bit 0 always zero
    assign imm_j = {
        {11{inst[31]}},
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21],
        1'b0
    };

    assign hit    = (opcode == `JAL_OPCODE);
    assign target = addr + imm_j;

endmodule

`default_nettype wire

/* tb_fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module tb_fetch_unit
    import fetch_pkg::*;
();

    localparam logic [31:0] SEED        = 32'hacf0_da9b;
    localparam int          NUM_ENTRIES = 400;
    localparam int          MAX_CYCLES  = 40 * NUM_ENTRIES;
    localparam int          TAG_LSB     = $clog2(`BP_ENTRIES) + 2;

    logic         clk = 1'b0;
    logic         reset;
    mem_req_t     mem_req;
    logic         mem_ready;
    mem_resp_t    mem_resp;
    redirect_t    redirect;
    bp_update_t   bp_update;
    fetch_entry_t fetch_out;
    logic         fetch_valid;
    logic         fetch_ready;

    integer       seed;
    integer       rnd;
    int           cycles;
    int           delivered;
    int           stall_left;
    logic [31:0]  expected_addr;
    logic         after_redirect;

    // predictor table as the model sees it
    logic         m_valid  [`BP_ENTRIES];
    logic [31:0]  m_tag    [`BP_ENTRIES];
    logic [31:0]  m_target [`BP_ENTRIES];
    logic [1:0]   m_ctr    [`BP_ENTRIES];

    always #20 clk = ~clk;

    fetch_unit i_fetch_unit (
        .clk         (clk),
        .reset       (reset),
        .mem_req     (mem_req),
        .mem_ready   (mem_ready),
        .mem_resp    (mem_resp),
        .redirect    (redirect),
        .bp_update   (bp_update),
        .fetch_out   (fetch_out),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready)
    );

    tb_imem #(
        .SEED (SEED)
    ) i_imem (
        .clk   (clk),
        .reset (reset),
        .req   (mem_req),
        .ready (mem_ready),
        .resp  (mem_resp)
    );

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [20:0] imm;
        logic [11:0] mix;
        logic [4:0]  link;
        imm  = {{13{addr[9]}}, addr[9:5], 3'b100};
        mix  = addr[13:2] ^ addr[25:14] ^ {addr[31:26], addr[1:0], 4'd0};
        link = addr[14:10] ^ addr[19:15] ^ addr[24:20] ^ addr[29:25]
               ^ {addr[31:30], addr[1:0], 1'b1};
        if (addr[4:2] == 3'b111) begin
            word_at = {imm[20], imm[10:1], imm[11], imm[19:12], link, `JAL_OPCODE};
        end else begin
            word_at = {mix, 5'd0, 3'b000, 5'd0, 7'b0010011};
        end
    endfunction

    function automatic logic [31:0] predict(input logic [31:0] pc);
        int idx;
        idx = int'((pc >> 2) & (`BP_ENTRIES - 1));
        if (m_valid[idx] && (m_tag[idx] == (pc >> TAG_LSB)) && (m_ctr[idx] >= 2'd2)) begin
            predict = m_target[idx];
        end else begin
            predict = pc + 32'd4;
        end
    endfunction

    task automatic train(input logic [31:0] pc, input logic taken, input logic [31:0] target);
        int   idx;
        logic hit;
        idx = int'((pc >> 2) & (`BP_ENTRIES - 1));
        hit = m_valid[idx] && (m_tag[idx] == (pc >> TAG_LSB));
        if (!hit) begin
            if (taken) begin
                m_valid[idx]  = 1'b1;
                m_tag[idx]    = pc >> TAG_LSB;
                m_target[idx] = target;
                m_ctr[idx]    = 2'd2;
            end
        end else if (taken) begin
            m_target[idx] = target;
            if (m_ctr[idx] != 2'd3) begin
                m_ctr[idx] = m_ctr[idx] + 2'd1;
            end
        end else if (m_ctr[idx] != 2'd0) begin
            m_ctr[idx] = m_ctr[idx] - 2'd1;
        end
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic take_entry(input fetch_entry_t e);
        check("addr", e.addr, expected_addr);
        check("inst", e.inst, word_at(e.addr));
        // JAL beats the predictor
        if (e.addr[4:2] == 3'b111) begin
            expected_addr = e.addr + {{24{e.addr[9]}}, e.addr[9:5], 3'b100};
        end else begin
            expected_addr = predict(e.addr);
        end
        delivered      = delivered + 1;
    endtask

    task automatic send_redirect();
        integer r;
        r              = $random(seed);
        redirect.valid = 1'b1;
        redirect.addr  = r & 32'h0000_01fc;
        expected_addr  = redirect.addr;
        after_redirect = 1'b1;
        r              = $random(seed);
        if (r[0]) begin
            bp_update.valid = 1'b1;
            bp_update.pc    = r & 32'h0000_01fc;
            bp_update.taken = (r[31:30] != 2'b00);
            r               = $random(seed);
            bp_update.target = r & 32'h0000_01fc;
            train(bp_update.pc, bp_update.taken, bp_update.target);
        end
    endtask

    task automatic drive_cycle();
        // the redirect of the last cycle has emptied the queue
        if (after_redirect) begin
            check("fetch_valid after redirect", {31'b0, fetch_valid}, 32'd0);
        end
        after_redirect = 1'b0;
        redirect  = '0;
        bp_update = '0;
        rnd       = $random(seed);
        if (stall_left > 0) begin
            stall_left  = stall_left - 1;
            fetch_ready = 1'b0;
        end else if (rnd[9:5] == 5'd0) begin
            // long enough to fill the queue
            stall_left  = 2 * `FETCH_QUEUE_DEPTH + int'(rnd[13:10]);
            fetch_ready = 1'b0;
        end else begin
            fetch_ready = (rnd[1:0] != 2'b00);
        end
        if (rnd[18:14] == 5'd0) begin
            send_redirect();
            fetch_ready = 1'b0;
        end
        if (fetch_valid && fetch_ready) begin
            take_entry(fetch_out);
        end
    endtask

    initial begin
        seed           = SEED;
        reset          = 1'b1;
        redirect       = '0;
        bp_update      = '0;
        fetch_ready    = 1'b0;
        cycles         = 0;
        delivered      = 0;
        stall_left     = 0;
        expected_addr  = `FETCH_RESET_PC;
        after_redirect = 1'b0;
        for (int i = 0; i < `BP_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (16) begin
            @(negedge clk);
            check("valid during reset", {30'b0, mem_req.valid, fetch_valid}, 32'd0);
        end
        reset = 1'b0;
        while (delivered < NUM_ENTRIES) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles >= MAX_CYCLES) begin
                $display("TEST FAILED");
                $fatal(1, "timeout, only %0d of %0d entries delivered in %0d cycles",
                       delivered, NUM_ENTRIES, cycles);
            end else begin
                drive_cycle();
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_imem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module tb_imem
    import fetch_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h0
) (
    input  logic      clk,
    input  logic      reset,
    input  mem_req_t  req,
    output logic      ready,
    output mem_resp_t resp
);

    integer      seed;
    integer      rnd;
    logic        accepted;
    logic [31:0] acc_addr;
    logic        busy;
    logic [31:0] busy_addr;
    int          wait_cnt;

    // every eighth word is a JAL, the rest are addi x0 with an address tag
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [20:0] imm;
        logic [11:0] mix;
        logic [4:0]  link;
        imm  = {{13{addr[9]}}, addr[9:5], 3'b100};
        mix  = addr[13:2] ^ addr[25:14] ^ {addr[31:26], addr[1:0], 4'd0};
        link = addr[14:10] ^ addr[19:15] ^ addr[24:20] ^ addr[29:25]
               ^ {addr[31:30], addr[1:0], 1'b1};
        if (addr[4:2] == 3'b111) begin
            word_at = {imm[20], imm[10:1], imm[11], imm[19:12], link, `JAL_OPCODE};
        end else begin
            word_at = {mix, 5'd0, 3'b000, 5'd0, 7'b0010011};
        end
    endfunction

    initial begin
        seed     = SEED;
        ready    = 1'b0;
        resp     = '0;
        busy     = 1'b0;
        wait_cnt = 0;
    end

    always @(posedge clk) begin
        accepted <= !reset && req.valid && ready;
        acc_addr <= req.addr;
    end

    always @(negedge clk) begin
        resp.valid = 1'b0;
        if (reset) begin
            busy  = 1'b0;
            ready = 1'b0;
        end else begin
            if (accepted) begin
                rnd       = $random(seed);
                busy      = 1'b1;
                busy_addr = acc_addr;
                wait_cnt  = 1 + (rnd & 3);
            end
            if (busy) begin
                wait_cnt = wait_cnt - 1;
                if (wait_cnt == 0) begin
                    busy      = 1'b0;
                    resp.valid = 1'b1;
                    resp.addr  = busy_addr;
                    resp.inst  = word_at(busy_addr);
                end
            end
            // free again in the cycle of the answer
            rnd   = $random(seed);
            ready = !busy && (rnd[1:0] != 2'b00);
        end
    end

endmodule

`default_nettype wire
